// ==== src/soc_consts.svh ====
// Widths, queue depth, address map and register indices, included by the RTL and the testbench
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

`define SOC_ADDR_W      16
`define SOC_DATA_W      32
`define SOC_ID_W        4
`define SOC_FIFO_DEPTH  4

// Address map, page = addr[ADDR_W-1:PAGE_LSB]
`define SOC_PAGE_LSB    8
`define SOC_SYS_PAGE    0
`define SOC_GPIO_PAGE   1
`define SOC_VERSION     32'h0001_0002
`define SOC_REG_IDX_W   4

// System page word indices
`define SOC_SYS_VERSION_IDX  0
`define SOC_SYS_SCRATCH_IDX  1
`define SOC_SYS_TCOUNT_IDX   2
`define SOC_SYS_TCMP_IDX     3

// GPIO page word indices
`define SOC_GPIO_OUT_IDX     0
`define SOC_GPIO_OE_IDX      1
`define SOC_GPIO_IN_IDX      2

`endif

// ==== src/soc_pkg.sv ====
// Types for AXI channels, queued requests and Wishbone traffic, used by the RTL and the testbench
`include "soc_consts.svh"

package soc_pkg;

   typedef enum logic {OP_READ, OP_WRITE} op_e;
   typedef enum logic [1:0] {TGT_SYS, TGT_GPIO, TGT_NONE} target_e;
   typedef enum logic [1:0] {RESP_OKAY = 2'b00, RESP_SLVERR = 2'b10} axi_resp_e;

   typedef struct packed {logic [`SOC_ID_W-1:0] id; logic [`SOC_ADDR_W-1:0] addr;} axi_aw_t;
   typedef struct packed {logic [`SOC_DATA_W-1:0] data; logic [`SOC_DATA_W/8-1:0] strb;} axi_w_t;
   typedef struct packed {logic [`SOC_ID_W-1:0] id; logic [`SOC_ADDR_W-1:0] addr;} axi_ar_t;
   typedef struct packed {logic [`SOC_ID_W-1:0] id; axi_resp_e resp;} axi_b_t;
   typedef struct packed {
      logic [`SOC_ID_W-1:0]   id;
      logic [`SOC_DATA_W-1:0] data;
      axi_resp_e              resp;
   } axi_r_t;

   typedef struct packed {
      op_e                      op;
      logic [`SOC_ID_W-1:0]     id;
      logic [`SOC_ADDR_W-1:0]   addr;
      logic [`SOC_DATA_W-1:0]   data;
      logic [`SOC_DATA_W/8-1:0] strb;
   } bus_req_t;

   // Address is the word index within the target page
   typedef struct packed {
      logic [`SOC_REG_IDX_W-1:0] adr;
      logic [`SOC_DATA_W-1:0]    dat;
      logic [`SOC_DATA_W/8-1:0]  sel;
      logic                      we;
   } wb_req_t;

   typedef struct packed {logic [`SOC_DATA_W-1:0] dat; logic ack;} wb_rsp_t;

   // Byte lanes with sel set take the new value
   function automatic logic [`SOC_DATA_W-1:0] byte_merge(
      input logic [`SOC_DATA_W-1:0]   old_val,
      input logic [`SOC_DATA_W-1:0]   new_val,
      input logic [`SOC_DATA_W/8-1:0] sel
   );
      logic [`SOC_DATA_W-1:0] res;
      res = old_val;
      for (int i = 0; i < `SOC_DATA_W/8; i++) begin
         if (sel[i]) begin
            res[8*i +: 8] = new_val[8*i +: 8];
         end
      end
      return res;
   endfunction

endpackage

// ==== src/axi_req_capture.sv ====
// AXI slave front end, takes write pairs and reads and pushes them as requests into the queue
`timescale 1ns/1ps

module axi_req_capture (
   input  logic              clk,
   input  logic              i_rst,
   input  soc_pkg::axi_aw_t  i_aw,
   input  logic              i_awvalid,
   output logic              o_awready,
   input  soc_pkg::axi_w_t   i_w,
   input  logic              i_wvalid,
   output logic              o_wready,
   input  soc_pkg::axi_ar_t  i_ar,
   input  logic              i_arvalid,
   output logic              o_arready,
   input  logic              i_full,
   output logic              o_push,
   output soc_pkg::bus_req_t o_req
);

   logic room;
   logic take_wr;
   logic take_rd;

   // A push still in flight may take the last free entry
   assign room    = ~i_full & ~o_push;
   // Writes only as address and data together, and ahead of reads
   assign take_wr = i_awvalid & i_wvalid & room;
   assign take_rd = i_arvalid & room & ~take_wr;

   assign o_awready = take_wr;
   assign o_wready  = take_wr;
   assign o_arready = take_rd;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_push <= 1'b0;
      end else begin
         o_push <= take_wr | take_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (take_wr) begin
         o_req.op   <= soc_pkg::OP_WRITE;
         o_req.id   <= i_aw.id;
         o_req.addr <= i_aw.addr;
         o_req.data <= i_w.data;
         o_req.strb <= i_w.strb;
      end else if (take_rd) begin
         o_req.op   <= soc_pkg::OP_READ;
         o_req.id   <= i_ar.id;
         o_req.addr <= i_ar.addr;
         o_req.data <= '0;
         o_req.strb <= '0;
      end
   end

endmodule

// ==== src/req_fifo.sv ====
// Request queue between the AXI capture and the Wishbone master, head visible without a pop
`timescale 1ns/1ps
`include "soc_consts.svh"

module req_fifo #(
   parameter int DEPTH = `SOC_FIFO_DEPTH
) (
   input  logic              clk,
   input  logic              i_rst,
   input  logic              i_push,
   input  soc_pkg::bus_req_t i_req,
   input  logic              i_pop,
   output soc_pkg::bus_req_t o_req,
   output logic              o_empty,
   output logic              o_full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

   soc_pkg::bus_req_t mem [DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [PTR_W:0]    count;
   logic              do_push;
   logic              do_pop;

   assign do_push = i_push & ~o_full;
   assign do_pop  = i_pop & ~o_empty;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= i_req;
      end
   end

   assign o_req   = mem[rd_ptr];
   assign o_empty = (count == '0);
   assign o_full  = (count == (PTR_W + 1)'(DEPTH));

endmodule

// ==== src/wb_master.sv ====
// Wishbone master, runs one cycle per queued request and returns the AXI B or R response
`timescale 1ns/1ps
`include "soc_consts.svh"

module wb_master (
   input  logic              clk,
   input  logic              i_rst,
   input  logic              i_empty,
   input  soc_pkg::bus_req_t i_req,
   output logic              o_pop,
   output soc_pkg::wb_req_t  o_wb,
   output logic              o_sys_stb,
   output logic              o_gpio_stb,
   input  soc_pkg::wb_rsp_t  i_sys,
   input  soc_pkg::wb_rsp_t  i_gpio,
   output soc_pkg::axi_b_t   o_b,
   output logic              o_bvalid,
   input  logic              i_bready,
   output soc_pkg::axi_r_t   o_r,
   output logic              o_rvalid,
   input  logic              i_rready
);

   localparam int PAGE_W = `SOC_ADDR_W - `SOC_PAGE_LSB;
   localparam logic [PAGE_W-1:0] SYS_PAGE  = PAGE_W'(`SOC_SYS_PAGE);
   localparam logic [PAGE_W-1:0] GPIO_PAGE = PAGE_W'(`SOC_GPIO_PAGE);

   typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_RESP_WR, ST_RESP_RD} state_e;

   state_e                 state;
   soc_pkg::target_e       head_tgt;
   soc_pkg::target_e       tgt;
   soc_pkg::op_e           cur_op;
   logic [`SOC_ID_W-1:0]   cur_id;
   logic                   done;
   logic [`SOC_DATA_W-1:0] rd_data;
   soc_pkg::axi_resp_e     resp;

   function automatic soc_pkg::target_e decode(input logic [`SOC_ADDR_W-1:0] addr);
      logic [PAGE_W-1:0] page;
      page = addr[`SOC_ADDR_W-1:`SOC_PAGE_LSB];
      if (page == SYS_PAGE) begin
         return soc_pkg::TGT_SYS;
      end else if (page == GPIO_PAGE) begin
         return soc_pkg::TGT_GPIO;
      end
      return soc_pkg::TGT_NONE;
   endfunction

   assign head_tgt = decode(i_req.addr);
   assign o_pop    = (state == ST_IDLE) & ~i_empty;

   // Unmapped page finishes without a bus cycle
   always_comb begin
      case (tgt)
         soc_pkg::TGT_SYS: begin
            done    = i_sys.ack;
            rd_data = i_sys.dat;
         end
         soc_pkg::TGT_GPIO: begin
            done    = i_gpio.ack;
            rd_data = i_gpio.dat;
         end
         default: begin
            done    = 1'b1;
            rd_data = '0;
         end
      endcase
   end

   assign resp = (tgt == soc_pkg::TGT_NONE) ? soc_pkg::RESP_SLVERR : soc_pkg::RESP_OKAY;

   // ****************************************
   // Control FSM
   // ****************************************
   always_ff @(posedge clk) begin
      if (i_rst) begin
         state      <= ST_IDLE;
         o_sys_stb  <= 1'b0;
         o_gpio_stb <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (o_pop) begin
                  state      <= ST_BUS;
                  o_sys_stb  <= (head_tgt == soc_pkg::TGT_SYS);
                  o_gpio_stb <= (head_tgt == soc_pkg::TGT_GPIO);
               end
            end
            ST_BUS: begin
               if (done) begin
                  o_sys_stb  <= 1'b0;
                  o_gpio_stb <= 1'b0;
                  state <= (cur_op == soc_pkg::OP_WRITE) ? ST_RESP_WR : ST_RESP_RD;
               end
            end
            ST_RESP_WR: begin
               if (i_bready) begin
                  state <= ST_IDLE;
               end
            end
            ST_RESP_RD: begin
               if (i_rready) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Request and response payload
   always_ff @(posedge clk) begin
      if (o_pop) begin
         tgt      <= head_tgt;
         cur_op   <= i_req.op;
         cur_id   <= i_req.id;
         o_wb.adr <= i_req.addr[`SOC_REG_IDX_W+1:2];
         o_wb.dat <= i_req.data;
         o_wb.sel <= i_req.strb;
         o_wb.we  <= (i_req.op == soc_pkg::OP_WRITE);
      end
      if ((state == ST_BUS) && done) begin
         o_b.id   <= cur_id;
         o_b.resp <= resp;
         o_r.id   <= cur_id;
         o_r.data <= rd_data;
         o_r.resp <= resp;
      end
   end

   assign o_bvalid = (state == ST_RESP_WR);
   assign o_rvalid = (state == ST_RESP_RD);

endmodule

// ==== src/sys_regs.sv ====
// System-control Wishbone target with version, scratch and a compare timer that drives an IRQ
`timescale 1ns/1ps
`include "soc_consts.svh"

module sys_regs (
   input  logic             clk,
   input  logic             i_rst,
   input  soc_pkg::wb_req_t i_wb,
   input  logic             i_stb,
   output soc_pkg::wb_rsp_t o_wb,
   output logic             o_timer_irq
);

   logic [`SOC_DATA_W-1:0] scratch;
   logic [`SOC_DATA_W-1:0] count;
   logic [`SOC_DATA_W-1:0] compare;
   logic [`SOC_DATA_W-1:0] rdata;
   logic                   ack;
   logic                   access;

   // One access per strobe, ack follows a cycle later
   assign access = i_stb & ~ack;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         ack     <= 1'b0;
         scratch <= '0;
         count   <= '0;
         compare <= '0;
      end else begin
         ack   <= access;
         count <= count + 1'b1;
         if (access && i_wb.we) begin
            case (int'(i_wb.adr))
               `SOC_SYS_SCRATCH_IDX:
                  scratch <= soc_pkg::byte_merge(scratch, i_wb.dat, i_wb.sel);
               `SOC_SYS_TCMP_IDX:
                  compare <= soc_pkg::byte_merge(compare, i_wb.dat, i_wb.sel);
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         case (int'(i_wb.adr))
            `SOC_SYS_VERSION_IDX: rdata <= `SOC_VERSION;
            `SOC_SYS_SCRATCH_IDX: rdata <= scratch;
            `SOC_SYS_TCOUNT_IDX:  rdata <= count;
            `SOC_SYS_TCMP_IDX:    rdata <= compare;
            default:              rdata <= '0;
         endcase
      end
   end

   assign o_wb.dat = rdata;
   assign o_wb.ack = ack;

   // Zero compare keeps the timer quiet
   assign o_timer_irq = (compare != '0) && (count >= compare);

endmodule

// ==== src/gpio_regs.sv ====
// GPIO Wishbone target with output data, output enable and a two-flop synchronized input
`timescale 1ns/1ps
`include "soc_consts.svh"

module gpio_regs (
   input  logic                   clk,
   input  logic                   i_rst,
   input  soc_pkg::wb_req_t       i_wb,
   input  logic                   i_stb,
   output soc_pkg::wb_rsp_t       o_wb,
   input  logic [`SOC_DATA_W-1:0] i_gpio_in,
   output logic [`SOC_DATA_W-1:0] o_gpio_out,
   output logic [`SOC_DATA_W-1:0] o_gpio_oe
);

   logic [`SOC_DATA_W-1:0] in_meta;
   logic [`SOC_DATA_W-1:0] in_sync;
   logic [`SOC_DATA_W-1:0] rdata;
   logic                   ack;
   logic                   access;

   assign access = i_stb & ~ack;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         ack        <= 1'b0;
         o_gpio_out <= '0;
         o_gpio_oe  <= '0;
         in_meta    <= '0;
         in_sync    <= '0;
      end else begin
         ack     <= access;
         in_meta <= i_gpio_in;
         in_sync <= in_meta;
         if (access && i_wb.we) begin
            case (int'(i_wb.adr))
               `SOC_GPIO_OUT_IDX:
                  o_gpio_out <= soc_pkg::byte_merge(o_gpio_out, i_wb.dat, i_wb.sel);
               `SOC_GPIO_OE_IDX:
                  o_gpio_oe <= soc_pkg::byte_merge(o_gpio_oe, i_wb.dat, i_wb.sel);
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         case (int'(i_wb.adr))
            `SOC_GPIO_OUT_IDX: rdata <= o_gpio_out;
            `SOC_GPIO_OE_IDX:  rdata <= o_gpio_oe;
            `SOC_GPIO_IN_IDX:  rdata <= in_sync;
            default:           rdata <= '0;
         endcase
      end
   end

   assign o_wb.dat = rdata;
   assign o_wb.ack = ack;

endmodule

// ==== src/io_bridge_top.sv ====
// I/O bridge top level, AXI slave port in, system-control and GPIO registers behind Wishbone
`timescale 1ns/1ps
`include "soc_consts.svh"

module io_bridge_top (
   input  logic                   clk,
   input  logic                   i_rst,
   input  soc_pkg::axi_aw_t       i_aw,
   input  logic                   i_awvalid,
   output logic                   o_awready,
   input  soc_pkg::axi_w_t        i_w,
   input  logic                   i_wvalid,
   output logic                   o_wready,
   input  soc_pkg::axi_ar_t       i_ar,
   input  logic                   i_arvalid,
   output logic                   o_arready,
   output soc_pkg::axi_b_t        o_b,
   output logic                   o_bvalid,
   input  logic                   i_bready,
   output soc_pkg::axi_r_t        o_r,
   output logic                   o_rvalid,
   input  logic                   i_rready,
   output logic                   o_timer_irq,
   input  logic [`SOC_DATA_W-1:0] i_gpio_in,
   output logic [`SOC_DATA_W-1:0] o_gpio_out,
   output logic [`SOC_DATA_W-1:0] o_gpio_oe
);

   soc_pkg::bus_req_t cap_req;
   soc_pkg::bus_req_t head_req;
   soc_pkg::wb_req_t  wb_req;
   soc_pkg::wb_rsp_t  sys_rsp;
   soc_pkg::wb_rsp_t  gpio_rsp;
   logic              fifo_push;
   logic              fifo_pop;
   logic              fifo_full;
   logic              fifo_empty;
   logic              sys_stb;
   logic              gpio_stb;

   // ****************************************
   // AXI side
   // ****************************************
   axi_req_capture axi_req_capture_inst (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_aw      (i_aw),
      .i_awvalid (i_awvalid),
      .o_awready (o_awready),
      .i_w       (i_w),
      .i_wvalid  (i_wvalid),
      .o_wready  (o_wready),
      .i_ar      (i_ar),
      .i_arvalid (i_arvalid),
      .o_arready (o_arready),
      .i_full    (fifo_full),
      .o_push    (fifo_push),
      .o_req     (cap_req)
   );

   req_fifo #(
      .DEPTH (`SOC_FIFO_DEPTH)
   ) req_fifo_inst (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_push  (fifo_push),
      .i_req   (cap_req),
      .i_pop   (fifo_pop),
      .o_req   (head_req),
      .o_empty (fifo_empty),
      .o_full  (fifo_full)
   );

   wb_master wb_master_inst (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_empty    (fifo_empty),
      .i_req      (head_req),
      .o_pop      (fifo_pop),
      .o_wb       (wb_req),
      .o_sys_stb  (sys_stb),
      .o_gpio_stb (gpio_stb),
      .i_sys      (sys_rsp),
      .i_gpio     (gpio_rsp),
      .o_b        (o_b),
      .o_bvalid   (o_bvalid),
      .i_bready   (i_bready),
      .o_r        (o_r),
      .o_rvalid   (o_rvalid),
      .i_rready   (i_rready)
   );

   // ****************************************
   // Wishbone targets
   // ****************************************
   sys_regs sys_regs_inst (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_wb        (wb_req),
      .i_stb       (sys_stb),
      .o_wb        (sys_rsp),
      .o_timer_irq (o_timer_irq)
   );

   gpio_regs gpio_regs_inst (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_wb       (wb_req),
      .i_stb      (gpio_stb),
      .o_wb       (gpio_rsp),
      .i_gpio_in  (i_gpio_in),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe)
   );

endmodule

// ==== bench/tb_io_bridge.sv ====
// Testbench for the I/O bridge, drives AXI requests and checks responses against a register model
`timescale 1ns/1ps
`include "soc_consts.svh"

module tb_io_bridge;

   localparam int ID_W     = `SOC_ID_W;
   localparam int N_ROUNDS = 4;
   localparam int N_BURST  = 40;
   // Timer 3, version 1, read-back rounds, GPIO input 2, unmapped 4, burst
   localparam int N_REQ      = 3 + 1 + N_ROUNDS * 6 + 2 + 4 + N_BURST;
   localparam int MAX_CYCLES = 40 * N_REQ + 200;

   typedef struct packed {
      logic            is_wr;
      logic            at_least;
      soc_pkg::axi_b_t b;
      soc_pkg::axi_r_t r;
   } exp_t;

   logic                   clk;
   logic                   i_rst;
   soc_pkg::axi_aw_t       i_aw;
   logic                   i_awvalid;
   logic                   o_awready;
   soc_pkg::axi_w_t        i_w;
   logic                   i_wvalid;
   logic                   o_wready;
   soc_pkg::axi_ar_t       i_ar;
   logic                   i_arvalid;
   logic                   o_arready;
   soc_pkg::axi_b_t        o_b;
   logic                   o_bvalid;
   logic                   i_bready;
   soc_pkg::axi_r_t        o_r;
   logic                   o_rvalid;
   logic                   i_rready;
   logic                   o_timer_irq;
   logic [`SOC_DATA_W-1:0] i_gpio_in;
   logic [`SOC_DATA_W-1:0] o_gpio_out;
   logic [`SOC_DATA_W-1:0] o_gpio_oe;

   integer seed       = 32'h2fd2;
   integer stall_seed = 32'h2fd2 ^ 32'h0000_ffff;
   int     cycles     = 0;
   int     b_errs     = 0;
   int     r_errs     = 0;
   int     order_errs = 0;
   int     hs_errs    = 0;
   int     gpio_errs  = 0;
   int     irq_errs   = 0;

   // Expected register image
   logic [`SOC_DATA_W-1:0] m_scratch;
   logic [`SOC_DATA_W-1:0] m_cmp;
   logic [`SOC_DATA_W-1:0] m_out;
   logic [`SOC_DATA_W-1:0] m_oe;
   logic [`SOC_DATA_W-1:0] m_in;
   exp_t                   exp_q[$];

   io_bridge_top io_bridge_top_inst (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_aw        (i_aw),
      .i_awvalid   (i_awvalid),
      .o_awready   (o_awready),
      .i_w         (i_w),
      .i_wvalid    (i_wvalid),
      .o_wready    (o_wready),
      .i_ar        (i_ar),
      .i_arvalid   (i_arvalid),
      .o_arready   (o_arready),
      .o_b         (o_b),
      .o_bvalid    (o_bvalid),
      .i_bready    (i_bready),
      .o_r         (o_r),
      .o_rvalid    (o_rvalid),
      .i_rready    (i_rready),
      .o_timer_irq (o_timer_irq),
      .i_gpio_in   (i_gpio_in),
      .o_gpio_out  (o_gpio_out),
      .o_gpio_oe   (o_gpio_oe)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Random stalls on both response channels
   initial begin
      i_bready <= 1'b0;
      i_rready <= 1'b0;
      forever begin
         @(posedge clk);
         i_bready <= ($random(stall_seed) % 4) != 0;
         i_rready <= ($random(stall_seed) % 4) != 0;
      end
   end

   initial begin
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles with %0d responses still outstanding",
               MAX_CYCLES, exp_q.size());
      $display("Test failed");
      $finish;
   end

   // ****************************************
   // Reference model
   // ****************************************
   function automatic logic [`SOC_DATA_W-1:0] lane_mask(input logic [`SOC_DATA_W/8-1:0] strb);
      logic [`SOC_DATA_W-1:0] m;
      for (int i = 0; i < `SOC_DATA_W/8; i++) begin
         m[8*i +: 8] = {8{strb[i]}};
      end
      return m;
   endfunction

   function automatic logic [`SOC_ADDR_W-1:0] reg_addr(input int page, input int idx);
      return `SOC_ADDR_W'((page << `SOC_PAGE_LSB) | (idx << 2));
   endfunction

   function automatic exp_t ref_access(input soc_pkg::op_e op, input logic [ID_W-1:0] id,
                                       input logic [`SOC_ADDR_W-1:0] addr,
                                       input logic [`SOC_DATA_W-1:0] data,
                                       input logic [`SOC_DATA_W/8-1:0] strb);
      exp_t                   e;
      logic [`SOC_DATA_W-1:0] m;
      int                     page;
      int                     idx;
      m     = lane_mask(strb);
      page  = int'(addr[`SOC_ADDR_W-1:`SOC_PAGE_LSB]);
      idx   = int'(addr[`SOC_REG_IDX_W+1:2]);
      e     = '0;
      e.is_wr  = (op == soc_pkg::OP_WRITE);
      e.b.id   = id;
      e.r.id   = id;
      e.b.resp = soc_pkg::RESP_OKAY;
      e.r.resp = soc_pkg::RESP_OKAY;
      if (page == `SOC_SYS_PAGE) begin
         if (e.is_wr && idx == `SOC_SYS_SCRATCH_IDX) m_scratch = (m_scratch & ~m) | (data & m);
         if (e.is_wr && idx == `SOC_SYS_TCMP_IDX) m_cmp = (m_cmp & ~m) | (data & m);
         case (idx)
            `SOC_SYS_VERSION_IDX: e.r.data = `SOC_VERSION;
            `SOC_SYS_SCRATCH_IDX: e.r.data = m_scratch;
            `SOC_SYS_TCMP_IDX:    e.r.data = m_cmp;
            `SOC_SYS_TCOUNT_IDX: begin
               // Free-running count, only a lower bound is known
               e.at_least = 1'b1;
               e.r.data   = m_cmp;
            end
            default: e.r.data = '0;
         endcase
      end else if (page == `SOC_GPIO_PAGE) begin
         if (e.is_wr && idx == `SOC_GPIO_OUT_IDX) m_out = (m_out & ~m) | (data & m);
         if (e.is_wr && idx == `SOC_GPIO_OE_IDX) m_oe = (m_oe & ~m) | (data & m);
         case (idx)
            `SOC_GPIO_OUT_IDX: e.r.data = m_out;
            `SOC_GPIO_OE_IDX:  e.r.data = m_oe;
            `SOC_GPIO_IN_IDX:  e.r.data = m_in;
            default:           e.r.data = '0;
         endcase
      end else begin
         e.b.resp = soc_pkg::RESP_SLVERR;
         e.r.resp = soc_pkg::RESP_SLVERR;
      end
      return e;
   endfunction

   // ****************************************
   // Compare tasks and response monitor
   // ****************************************
   task automatic check_b(input soc_pkg::axi_b_t got, input soc_pkg::axi_b_t want);
      if (got !== want) begin
         b_errs++;
         $display("ERR %0t: B id=%0h resp=%0h, expected id=%0h resp=%0h",
                  $time, got.id, got.resp, want.id, want.resp);
      end
   endtask

   task automatic check_r(input soc_pkg::axi_r_t got, input soc_pkg::axi_r_t want,
                          input logic at_least);
      logic bad;
      if (at_least) begin
         bad = (got.id !== want.id) || (got.resp !== want.resp) || !(got.data >= want.data);
      end else begin
         bad = (got !== want);
      end
      if (bad) begin
         r_errs++;
         $display("ERR %0t: R id=%0h data=%h resp=%0h, expected id=%0h data=%s%h resp=%0h",
                  $time, got.id, got.data, got.resp, want.id, at_least ? ">=" : "",
                  want.data, want.resp);
      end
   endtask

   task automatic check_gpio(input logic [`SOC_DATA_W-1:0] got_out,
                             input logic [`SOC_DATA_W-1:0] got_oe,
                             input logic [`SOC_DATA_W-1:0] want_out,
                             input logic [`SOC_DATA_W-1:0] want_oe);
      if (got_out !== want_out || got_oe !== want_oe) begin
         gpio_errs++;
         $display("ERR %0t: GPIO out=%h oe=%h, expected out=%h oe=%h",
                  $time, got_out, got_oe, want_out, want_oe);
      end
   endtask

   // Handshakes seen here complete at the following rising edge
   always @(negedge clk) begin : watch_rsp
      exp_t e;
      if (i_rst === 1'b0 && o_awready !== o_wready) begin
         hs_errs++;
         $display("Write address ready and write data ready differ at %0t", $time);
      end
      if (i_rst === 1'b0 && o_bvalid === 1'b1 && i_bready === 1'b1) begin
         if (exp_q.size() == 0 || !exp_q[0].is_wr) begin
            order_errs++;
            $display("Write response at %0t does not match the next outstanding request", $time);
         end else begin
            e = exp_q.pop_front();
            check_b(o_b, e.b);
         end
      end
      if (i_rst === 1'b0 && o_rvalid === 1'b1 && i_rready === 1'b1) begin
         if (exp_q.size() == 0 || exp_q[0].is_wr) begin
            order_errs++;
            $display("Read response at %0t does not match the next outstanding request", $time);
         end else begin
            e = exp_q.pop_front();
            check_r(o_r, e.r, e.at_least);
         end
      end
   end

   // ****************************************
   // AXI driver
   // ****************************************
   task automatic send_write(input logic [`SOC_ADDR_W-1:0] addr,
                             input logic [`SOC_DATA_W-1:0] data,
                             input logic [`SOC_DATA_W/8-1:0] strb);
      logic [ID_W-1:0] id;
      id = ID_W'($random(seed));
      @(posedge clk);
      i_aw.id   <= id;
      i_aw.addr <= addr;
      i_w.data  <= data;
      i_w.strb  <= strb;
      i_awvalid <= 1'b1;
      i_wvalid  <= 1'b1;
      do @(negedge clk); while (o_awready !== 1'b1);
      exp_q.push_back(ref_access(soc_pkg::OP_WRITE, id, addr, data, strb));
      @(posedge clk);
      i_awvalid <= 1'b0;
      i_wvalid  <= 1'b0;
   endtask

   task automatic send_read(input logic [`SOC_ADDR_W-1:0] addr);
      logic [ID_W-1:0] id;
      id = ID_W'($random(seed));
      @(posedge clk);
      i_ar.id   <= id;
      i_ar.addr <= addr;
      i_arvalid <= 1'b1;
      do @(negedge clk); while (o_arready !== 1'b1);
      exp_q.push_back(ref_access(soc_pkg::OP_READ, id, addr, '0, '0));
      @(posedge clk);
      i_arvalid <= 1'b0;
   endtask

   task automatic drain;
      do @(negedge clk); while (exp_q.size() != 0);
      @(negedge clk);
   endtask

   // ****************************************
   // Tests
   // ****************************************
   task automatic timer_test;
      int waited;
      waited = 0;
      send_write(reg_addr(`SOC_SYS_PAGE, `SOC_SYS_TCMP_IDX), 32'd50, '1);
      drain;
      if (o_timer_irq !== 1'b0) begin
         irq_errs++;
         $display("Timer interrupt already high right after the compare write at %0t", $time);
      end
      while (o_timer_irq !== 1'b1 && waited < 100) begin
         @(negedge clk);
         waited++;
      end
      if (o_timer_irq !== 1'b1) begin
         irq_errs++;
         $display("Timer interrupt not raised within 100 cycles of the compare write");
      end
      send_read(reg_addr(`SOC_SYS_PAGE, `SOC_SYS_TCOUNT_IDX));
      send_write(reg_addr(`SOC_SYS_PAGE, `SOC_SYS_TCMP_IDX), '0, '1);
      drain;
      if (o_timer_irq !== 1'b0) begin
         irq_errs++;
         $display("Timer interrupt still high after the compare was cleared at %0t", $time);
      end
   endtask

   task automatic readback_test;
      logic [`SOC_ADDR_W-1:0] addrs [3];
      logic [`SOC_DATA_W-1:0] data;
      addrs[0] = reg_addr(`SOC_SYS_PAGE, `SOC_SYS_SCRATCH_IDX);
      addrs[1] = reg_addr(`SOC_GPIO_PAGE, `SOC_GPIO_OUT_IDX);
      addrs[2] = reg_addr(`SOC_GPIO_PAGE, `SOC_GPIO_OE_IDX);
      for (int n = 0; n < N_ROUNDS; n++) begin
         for (int k = 0; k < 3; k++) begin
            data = $random(seed);
            send_write(addrs[k], data, (`SOC_DATA_W/8)'($random(seed)));
            send_read(addrs[k]);
         end
      end
      drain;
      check_gpio(o_gpio_out, o_gpio_oe, m_out, m_oe);
   endtask

   task automatic burst_test;
      int                     sel;
      logic [`SOC_ADDR_W-1:0] addr;
      for (int n = 0; n < N_BURST; n++) begin
         sel = int'($unsigned($random(seed)) % 6);
         case (sel)
            0:       addr = reg_addr(`SOC_SYS_PAGE, `SOC_SYS_VERSION_IDX);
            1:       addr = reg_addr(`SOC_SYS_PAGE, `SOC_SYS_SCRATCH_IDX);
            2:       addr = reg_addr(`SOC_GPIO_PAGE, `SOC_GPIO_OUT_IDX);
            3:       addr = reg_addr(`SOC_GPIO_PAGE, `SOC_GPIO_OE_IDX);
            4:       addr = reg_addr(`SOC_GPIO_PAGE, `SOC_GPIO_IN_IDX);
            default: addr = reg_addr(3, 0);
         endcase
         if ($random(seed) % 2 == 0) begin
            send_write(addr, $random(seed), (`SOC_DATA_W/8)'($random(seed)));
         end else begin
            send_read(addr);
         end
      end
      drain;
      check_gpio(o_gpio_out, o_gpio_oe, m_out, m_oe);
   endtask

   initial begin
      i_rst     <= 1'b1;
      i_aw      <= '0;
      i_awvalid <= 1'b0;
      i_w       <= '0;
      i_wvalid  <= 1'b0;
      i_ar      <= '0;
      i_arvalid <= 1'b0;
      i_gpio_in <= '0;
      m_scratch = '0;
      m_cmp     = '0;
      m_out     = '0;
      m_oe      = '0;
      m_in      = '0;
      repeat (10) @(posedge clk);
      i_rst <= 1'b0;

      // Timer first, while the count is still below the compare
      timer_test;
      send_read(reg_addr(`SOC_SYS_PAGE, `SOC_SYS_VERSION_IDX));
      readback_test;
      for (int n = 0; n < 2; n++) begin
         @(posedge clk);
         m_in = $random(seed);
         i_gpio_in <= m_in;
         repeat (5) @(posedge clk);
         send_read(reg_addr(`SOC_GPIO_PAGE, `SOC_GPIO_IN_IDX));
         drain;
      end
      send_write(reg_addr(2, 0), $random(seed), '1);
      send_read(reg_addr(2, 0));
      send_write(reg_addr(8'hff, 1), $random(seed), '1);
      send_read(reg_addr(8'hff, 1));
      burst_test;
      drain;

      $display("Errors: B %0d, R %0d, order %0d, handshake %0d, GPIO %0d, timer %0d",
               b_errs, r_errs, order_errs, hs_errs, gpio_errs, irq_errs);
      if (b_errs + r_errs + order_errs + hs_errs + gpio_errs + irq_errs == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+src
src/soc_pkg.sv
src/axi_req_capture.sv
src/req_fifo.sv
src/wb_master.sv
src/sys_regs.sv
src/gpio_regs.sv
src/io_bridge_top.sv
bench/tb_io_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the I/O bridge testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_io_bridge \
   && ./obj_dir/Vtb_io_bridge | tee /dev/stderr | grep "Test completed successfully" > /dev/null \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
